//--- sim.f
+incdir+source
source/serializer_pkg.sv
source/lowbit.sv
source/ready_list.sv
source/running_hint_table.sv
source/task_payload_ram.sv
source/serializer_ctrl.sv
source/conflict_serializer_top.sv
verification/serializer_clkgen.sv
verification/serializer_props.sv
verification/serializer_tb.sv

//--- Bender.yml
package:
  name: conflict_serializer

sources:
  - include_dirs:
      - source
    files:
      - source/serializer_pkg.sv
      - source/lowbit.sv
      - source/ready_list.sv
      - source/running_hint_table.sv
      - source/task_payload_ram.sv
      - source/serializer_ctrl.sv
      - source/conflict_serializer_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verification/serializer_clkgen.sv
      - verification/serializer_props.sv
      - verification/serializer_tb.sv

//--- verification/serializer_tb.sv
`include "serializer_defs.svh"

module serializer_tb import serializer_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int wait_limit = 50;
   localparam ttype_t any_type = `SER_TTYPE_ANY;

   logic clk;
   logic rstn;
   logic m_valid;
   task_t m_task;
   slot_t m_slot;
   logic m_ready;
   logic [`SER_NUM_CORES-1:0] s_arvalid;
   ttype_t [`SER_NUM_CORES-1:0] s_araddr;
   logic [`SER_NUM_CORES-1:0] s_rvalid;
   task_t s_rdata;
   slot_t s_slot;
   logic finished_valid;
   core_id_t finished_core;
   count_t size_limit;
   logic almost_full;
   logic all_cores_idle;
   integer seed;
   int errors;
   int checks;
   int tests;

   serializer_clkgen i_serializer_clkgen (.clk(clk), .rstn(rstn));

   conflict_serializer_top i_conflict_serializer_top (
      .clk(clk), .rstn(rstn), .m_valid(m_valid), .m_task(m_task), .m_slot(m_slot),
      .m_ready(m_ready), .s_arvalid(s_arvalid), .s_araddr(s_araddr), .s_rvalid(s_rvalid),
      .s_rdata(s_rdata), .s_slot(s_slot), .finished_valid(finished_valid),
      .finished_core(finished_core), .size_limit(size_limit), .almost_full(almost_full),
      .all_cores_idle(all_cores_idle)
   );

   bind conflict_serializer_top serializer_props i_serializer_props (
      .clk(clk), .rstn(rstn), .m_valid(m_valid), .m_ready(m_ready),
      .s_arvalid(s_arvalid), .s_rvalid(s_rvalid)
   );

   task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic timed_out(input string what);
      $display("timeout at %0t ns: %s did not arrive in %0d cycles", $time, what, wait_limit);
      errors++;
   endtask

   function automatic task_t make_task(input ttype_t tt, input int idx);
      task_t t;
      logic [31:0] r;
      r = $random(seed);
      t.ttype = tt;
      // low bits keep the hints of one test distinct
      t.hint = {r[15:5], 5'(idx)};
      t.ts = r[31:16];
      return t;
   endfunction

   // a dispatched task carries its hint without the read-only flag
   function automatic task_t strip_ro(input task_t t);
      task_t d;
      d = t;
      d.hint[`SER_HINT_W-1] = 1'b0;
      return d;
   endfunction

   task automatic wait_accept();
      int n;
      n = 0;
      @(negedge clk);
      while (!m_ready && n < wait_limit) begin
         @(negedge clk);
         n++;
      end
      if (!m_ready) timed_out("m_ready");
      @(posedge clk);
      m_valid <= 1'b0;
   endtask

   task automatic enqueue(input task_t t, input int slot);
      @(posedge clk);
      m_valid <= 1'b1;
      m_task <= t;
      m_slot <= slot_t'(slot);
      wait_accept();
   endtask

   task automatic wait_grant(input int core);
      int n;
      n = 0;
      @(negedge clk);
      while (!s_rvalid[core] && n < wait_limit) begin
         @(negedge clk);
         n++;
      end
      if (!s_rvalid[core]) timed_out($sformatf("s_rvalid for core %0d", core));
   endtask

   task automatic request(input int core, input ttype_t tt);
      s_arvalid[core] <= 1'b1;
      s_araddr[core] <= tt;
   endtask

   // request, wait for the strobe, check the payload, then release
   task automatic serve(input int core, input ttype_t tt, input task_t exp, input int slot);
      @(posedge clk);
      request(core, tt);
      wait_grant(core);
      check(s_rdata, strip_ro(exp), $sformatf("s_rdata to core %0d", core));
      check(s_slot, slot, $sformatf("s_slot to core %0d", core));
      @(posedge clk);
      s_arvalid[core] <= 1'b0;
   endtask

   task automatic finish(input int core);
      @(posedge clk);
      finished_valid <= 1'b1;
      finished_core <= core_id_t'(core);
      @(posedge clk);
      finished_valid <= 1'b0;
   endtask

   task automatic test_done(input string name, input int e0);
      tests++;
      $display("test %s finished with %0d failures", name, errors - e0);
   endtask

   task automatic basic_dispatch();
      task_t t;
      int e0;
      e0 = errors;
      check(s_rvalid, 0, "s_rvalid after reset");
      check(almost_full, 0, "almost_full after reset");
      check(all_cores_idle, 1, "all_cores_idle after reset");
      t = make_task(3'd1, 1);
      t.hint[`SER_HINT_W-1] = 1'b1;
      enqueue(t, 3);
      serve(0, 3'd1, t, 3);
      @(negedge clk);
      check(all_cores_idle, 0, "all_cores_idle while core 0 runs");
      finish(0);
      @(negedge clk);
      check(all_cores_idle, 1, "all_cores_idle after finish");
      test_done("basic dispatch", e0);
   endtask

   task automatic serialize_pair(input string name, input hint_t ha, input hint_t hb);
      task_t first;
      task_t second;
      int e0;
      e0 = errors;
      first = make_task(3'd2, 2);
      first.hint = ha;
      second = make_task(3'd2, 3);
      second.hint = hb;
      enqueue(first, 1);
      enqueue(second, 2);
      @(posedge clk);
      request(0, 3'd2);
      request(1, 3'd2);
      wait_grant(0);
      check(s_rvalid, 4'b0001, "only core 0 granted");
      check(s_slot, 1, "s_slot to core 0");
      @(posedge clk);
      s_arvalid[0] <= 1'b0;
      // same hint is running on core 0, so core 1 must wait
      repeat (6) begin
         @(negedge clk);
         check(s_rvalid[1], 0, "core 1 held while hint runs");
      end
      finish(0);
      wait_grant(1);
      check(s_rdata, strip_ro(second), "s_rdata to core 1");
      check(s_slot, 2, "s_slot to core 1");
      @(posedge clk);
      s_arvalid[1] <= 1'b0;
      finish(1);
      test_done(name, e0);
   endtask

   task automatic type_order();
      task_t t [3];
      int e0;
      e0 = errors;
      t[0] = make_task(3'd1, 4);
      t[1] = make_task(3'd2, 5);
      t[2] = make_task(3'd1, 6);
      for (int k = 0; k < 3; k++) begin
         enqueue(t[k], 4 + k);
      end
      serve(0, 3'd1, t[0], 4);
      serve(1, any_type, t[1], 5);
      serve(2, 3'd1, t[2], 6);
      finish(0);
      finish(1);
      finish(2);
      test_done("type matching and order", e0);
   endtask

   task automatic capacity();
      task_t q [$];
      int e0;
      e0 = errors;
      @(posedge clk);
      size_limit <= 4;
      for (int k = 0; k < `SER_LIST_DEPTH; k++) begin
         q.push_back(make_task(3'd4, k));
         enqueue(q[k], k);
         @(negedge clk);
         check(almost_full, (k + 1 >= 4), $sformatf("almost_full at %0d tasks", k + 1));
      end
      // one more task waits at the queue until a grant frees an entry
      q.push_back(make_task(3'd4, `SER_LIST_DEPTH));
      @(posedge clk);
      m_valid <= 1'b1;
      m_task <= q[`SER_LIST_DEPTH];
      m_slot <= slot_t'(`SER_LIST_DEPTH);
      repeat (3) begin
         @(negedge clk);
         check(m_ready, 0, "m_ready with the list full");
      end
      serve(0, any_type, q[0], 0);
      wait_accept();
      finish(0);
      for (int k = 1; k <= `SER_LIST_DEPTH; k++) begin
         serve(0, any_type, q[k], k);
         finish(0);
      end
      @(posedge clk);
      size_limit <= count_t'(`SER_LIST_DEPTH);
      test_done("capacity", e0);
   endtask

   task automatic arbitration();
      task_t t [3];
      int e0;
      e0 = errors;
      for (int k = 0; k < 3; k++) begin
         t[k] = make_task(3'd3, 8 + k);
         enqueue(t[k], 8 + k);
      end
      @(posedge clk);
      request(1, 3'd3);
      request(2, 3'd3);
      wait_grant(1);
      check(s_rvalid, 4'b0010, "core 1 served first");
      check(s_rdata, strip_ro(t[0]), "s_rdata to core 1");
      @(posedge clk);
      s_arvalid[1] <= 1'b0;
      wait_grant(2);
      check(s_rdata, strip_ro(t[1]), "s_rdata to core 2");
      check(s_slot, 9, "s_slot to core 2");
      @(posedge clk);
      s_arvalid[2] <= 1'b0;
      finish(1);
      finish(2);
      serve(1, 3'd3, t[2], 10);
      finish(1);
      // the list must now be empty
      @(posedge clk);
      request(3, any_type);
      repeat (5) begin
         @(negedge clk);
         check(s_rvalid, 0, "no task served twice");
      end
      @(posedge clk);
      s_arvalid[3] <= 1'b0;
      test_done("arbitration", e0);
   endtask

   initial begin
      logic [31:0] r;
      int n;
      seed = 32'h98bfb944;
      errors = 0;
      checks = 0;
      tests = 0;
      m_valid = 1'b0;
      m_task = '0;
      m_slot = '0;
      s_arvalid = '0;
      s_araddr = '0;
      finished_valid = 1'b0;
      finished_core = '0;
      size_limit = count_t'(`SER_LIST_DEPTH);
      n = 0;
      // rstn may still be unknown at time zero
      while (rstn !== 1'b1 && n < wait_limit) begin
         @(negedge clk);
         n++;
      end
      if (rstn !== 1'b1) timed_out("reset release");
      basic_dispatch();
      r = $random(seed);
      serialize_pair("serialization", r[15:0], r[15:0]);
      type_order();
      r = $random(seed);
      serialize_pair("read-only flag", {1'b1, r[14:0]}, {1'b0, r[14:0]});
      capacity();
      arbitration();
      $display("summary: %0d tests, %0d checks, %0d failures", tests, checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end
endmodule

//--- verification/serializer_props.sv
`include "serializer_defs.svh"

module serializer_props (
   input logic clk,
   input logic rstn,
   input logic m_valid,
   input logic m_ready,
   input logic [`SER_NUM_CORES-1:0] s_arvalid,
   input logic [`SER_NUM_CORES-1:0] s_rvalid
);
   timeunit 1ns;
   timeprecision 100ps;

   // at most one core is served per cycle
   rvalid_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(s_rvalid))
      else $error("s_rvalid has more than one bit set");

   // the queue is only acknowledged while it offers a task
   ready_needs_valid: assert property (@(posedge clk) disable iff (!rstn) m_ready |-> m_valid)
      else $error("m_ready high while m_valid is low");

   rvalid_needs_request: assert property (@(posedge clk) disable iff (!rstn)
      (s_rvalid & ~$past(s_arvalid)) == '0)
      else $error("s_rvalid to a core that did not request in the previous cycle");
endmodule

//--- verification/serializer_clkgen.sv
module serializer_clkgen (
   output logic clk,
   output logic rstn
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // reset held low for the first three rising edges
   initial begin
      rstn = 1'b0;
      repeat (3) @(posedge clk);
      rstn <= 1'b1;
   end
endmodule

//--- source/conflict_serializer_top.sv
`include "serializer_defs.svh"

module conflict_serializer_top import serializer_pkg::*; (
   input logic clk,
   input logic rstn,
   // task queue side
   input logic m_valid,
   input task_t m_task,
   input slot_t m_slot,
   output logic m_ready,
   // core side
   input logic [`SER_NUM_CORES-1:0] s_arvalid,
   input ttype_t [`SER_NUM_CORES-1:0] s_araddr,
   output logic [`SER_NUM_CORES-1:0] s_rvalid,
   output task_t s_rdata,
   output slot_t s_slot,
   input logic finished_valid,
   input core_id_t finished_core,
   // status
   input count_t size_limit,
   output logic almost_full,
   output logic all_cores_idle
);

   logic [`SER_NUM_TYPES-1:0][`SER_LIST_DEPTH-1:0] type_ready;
   entry_t [`SER_LIST_DEPTH-1:0] entries;
   grant_t grant;
   slot_t pick_slot;
   count_t occupancy;
   logic insert_conflict;
   hint_t finished_hint;

   serializer_ctrl i_serializer_ctrl (
      .clk(clk),
      .rstn(rstn),
      .s_arvalid(s_arvalid),
      .s_araddr(s_araddr),
      .type_ready(type_ready),
      .entries(entries),
      .grant(grant),
      .s_rvalid(s_rvalid),
      .pick_slot(pick_slot),
      .s_slot(s_slot),
      .enq_fire(m_ready),
      .occupancy(occupancy),
      .size_limit(size_limit),
      .almost_full(almost_full)
   );

   ready_list i_ready_list (
      .clk(clk),
      .rstn(rstn),
      .enq_valid(m_valid),
      .enq_task(m_task),
      .enq_slot(m_slot),
      .enq_conflict(insert_conflict),
      .enq_ready(m_ready),
      .grant(grant),
      .finished_valid(finished_valid),
      .finished_hint(finished_hint),
      .type_ready(type_ready),
      .entries(entries),
      .occupancy(occupancy)
   );

   running_hint_table i_running_hint_table (
      .clk(clk),
      .rstn(rstn),
      .grant_valid(grant.valid),
      .grant_core(grant.core),
      .grant_hint(s_rdata.hint),
      .finished_valid(finished_valid),
      .finished_core(finished_core),
      .probe_hint(m_task.hint),
      .probe_conflict(insert_conflict),
      .finished_hint(finished_hint),
      .all_cores_idle(all_cores_idle)
   );

   task_payload_ram i_task_payload_ram (
      .clk(clk),
      .wr_en(m_ready),
      .wr_slot(m_slot),
      .wr_task(m_task),
      .rd_slot(pick_slot),
      .rd_task(s_rdata)
   );

endmodule

//--- source/serializer_ctrl.sv
`include "serializer_defs.svh"

module serializer_ctrl import serializer_pkg::*; (
   input logic clk,
   input logic rstn,
   input logic [`SER_NUM_CORES-1:0] s_arvalid,
   input ttype_t [`SER_NUM_CORES-1:0] s_araddr,
   input logic [`SER_NUM_TYPES-1:0][`SER_LIST_DEPTH-1:0] type_ready,
   input entry_t [`SER_LIST_DEPTH-1:0] entries,
   output grant_t grant,
   output logic [`SER_NUM_CORES-1:0] s_rvalid,
   output slot_t pick_slot,
   output slot_t s_slot,
   input logic enq_fire,
   input count_t occupancy,
   input count_t size_limit,
   output logic almost_full
);

   localparam int num_cores = `SER_NUM_CORES;
   localparam int depth = `SER_LIST_DEPTH;

   logic [num_cores-1:0] can_take;
   core_id_t core_sel;
   list_idx_t task_sel;
   logic [depth-1:0] pick_vec;
   count_t occ_next;

   // a core just served gets one cycle off
   always_comb begin
      for (int i = 0; i < num_cores; i++) begin
         can_take[i] = s_arvalid[i] && (type_ready[s_araddr[i]] != '0)
            && !(grant.valid && grant.core == i);
      end
   end

   lowbit #(.in_width(num_cores)) i_core_pick (
      .in(can_take),
      .out(core_sel)
   );

   assign pick_vec = type_ready[s_araddr[core_sel]];

   lowbit #(.in_width(depth)) i_task_pick (
      .in(pick_vec),
      .out(task_sel)
   );

   assign pick_slot = entries[task_sel].slot;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         grant.valid <= 1'b0;
      end else begin
         grant.valid <= |can_take;
         grant.core <= core_sel;
         // the previous grant shifts the list down at this edge
         if (grant.valid && task_sel > grant.idx) begin
            grant.idx <= task_sel - 1'b1;
         end else begin
            grant.idx <= task_sel;
         end
      end
   end

   always_ff @(posedge clk) begin
      s_slot <= pick_slot;
   end

   always_comb begin
      for (int i = 0; i < num_cores; i++) begin
         s_rvalid[i] = grant.valid && grant.core == i;
      end
   end

   // occupancy after this edge, compared against the threshold
   assign occ_next = occupancy + count_t'(enq_fire) - count_t'(grant.valid);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         almost_full <= 1'b0;
      end else begin
         almost_full <= (occ_next >= size_limit);
      end
   end

endmodule

//--- source/task_payload_ram.sv
`include "serializer_defs.svh"

module task_payload_ram import serializer_pkg::*; (
   input logic clk,
   input logic wr_en,
   input slot_t wr_slot,
   input task_t wr_task,
   input slot_t rd_slot,
   output task_t rd_task
);

   task_t mem [2**`SER_SLOT_W];
   task_t wr_data;

   // stored as dispatched, with the read-only flag dropped
   always_comb begin
      wr_data = wr_task;
      wr_data.hint = ser_mask_hint(wr_task.hint);
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_slot] <= wr_data;
      end
   end

   // read at the arbitration edge, valid together with s_rvalid
   always_ff @(posedge clk) begin
      rd_task <= mem[rd_slot];
   end

endmodule

//--- source/running_hint_table.sv
`include "serializer_defs.svh"

module running_hint_table import serializer_pkg::*; (
   input logic clk,
   input logic rstn,
   input logic grant_valid,
   input core_id_t grant_core,
   input hint_t grant_hint,
   input logic finished_valid,
   input core_id_t finished_core,
   input hint_t probe_hint,
   output logic probe_conflict,
   output hint_t finished_hint,
   output logic all_cores_idle
);

   localparam int num_cores = `SER_NUM_CORES;

   logic [num_cores-1:0] run_valid;
   hint_t run_hint [num_cores];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         run_valid <= '0;
      end else begin
         for (int j = 0; j < num_cores; j++) begin
            if (grant_valid && grant_core == j) begin
               run_valid[j] <= 1'b1;
            end else if (finished_valid && finished_core == j) begin
               run_valid[j] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (grant_valid) begin
         run_hint[grant_core] <= grant_hint;
      end
   end

   assign finished_hint = run_hint[finished_core];
   assign all_cores_idle = ~|run_valid;

   // a core that finishes this cycle no longer blocks the incoming hint
   always_comb begin
      probe_conflict = 1'b0;
      for (int j = 0; j < num_cores; j++) begin
         if (run_valid[j] && run_hint[j] == ser_mask_hint(probe_hint)
               && !(finished_valid && finished_core == j)) begin
            probe_conflict = 1'b1;
         end
      end
   end

endmodule

//--- source/ready_list.sv
`include "serializer_defs.svh"

module ready_list import serializer_pkg::*; (
   input logic clk,
   input logic rstn,
   input logic enq_valid,
   input task_t enq_task,
   input slot_t enq_slot,
   input logic enq_conflict,
   output logic enq_ready,
   input grant_t grant,
   input logic finished_valid,
   input hint_t finished_hint,
   output logic [`SER_NUM_TYPES-1:0][`SER_LIST_DEPTH-1:0] type_ready,
   output entry_t [`SER_LIST_DEPTH-1:0] entries,
   output count_t occupancy
);

   localparam int depth = `SER_LIST_DEPTH;

   entry_t list [depth];
   logic [depth-1:0] valid_vec;
   logic [depth-1:0] fin_hit;
   list_idx_t fin_sel;
   list_idx_t ins_loc;
   logic list_hit;
   entry_t new_entry;

   // entries stay packed from index 0, so the first hole is the tail
   lowbit #(.in_width(depth)) i_insert_pick (
      .in(~valid_vec),
      .out(ins_loc)
   );

   // earliest pending entry waiting on the finished hint
   lowbit #(.in_width(depth)) i_finish_pick (
      .in(fin_hit),
      .out(fin_sel)
   );

   assign enq_ready = enq_valid & ~valid_vec[ins_loc];

   always_comb begin
      list_hit = 1'b0;
      for (int k = 0; k < depth; k++) begin
         if (list[k].valid && list[k].hint == ser_mask_hint(enq_task.hint)) begin
            list_hit = 1'b1;
         end
      end
   end

   always_comb begin
      new_entry.ttype = enq_task.ttype;
      new_entry.hint = ser_mask_hint(enq_task.hint);
      new_entry.slot = enq_slot;
      new_entry.valid = 1'b1;
      new_entry.conflict = enq_conflict | list_hit;
   end

   always_comb begin
      occupancy = '0;
      for (int k = 0; k < depth; k++) begin
         occupancy = occupancy + count_t'(valid_vec[k]);
      end
   end

   for (genvar i = 0; i < depth; i++) begin : g_entry
      // what slides into this position on a shift
      entry_t upper;

      assign valid_vec[i] = list[i].valid;
      assign entries[i] = list[i];
      assign fin_hit[i] = finished_valid & list[i].valid & (list[i].hint == finished_hint);

      if (i == depth - 1) begin : g_tail
         assign upper = '0;
      end else begin : g_body
         // a finish match moves down together with its entry
         always_comb begin
            upper = list[i+1];
            if (fin_hit[i+1] && fin_sel == i + 1) begin
               upper.conflict = 1'b0;
            end
         end
      end

      // entry taken by the stage-1 grant is not offered again
      for (genvar t = 0; t < `SER_NUM_TYPES; t++) begin : g_type
         assign type_ready[t][i] = list[i].valid & ~list[i].conflict
            & ((t == `SER_TTYPE_ANY) || (list[i].ttype == t))
            & ~(grant.valid && grant.idx == i);
      end

      always_ff @(posedge clk) begin
         if (!rstn) begin
            list[i].valid <= 1'b0;
            list[i].conflict <= 1'b0;
         end else if (grant.valid && i >= grant.idx) begin
            // new task lands one place lower, behind the shifted entries
            if (enq_ready && ins_loc == i + 1) begin
               list[i] <= new_entry;
            end else begin
               list[i] <= upper;
            end
         end else if (enq_ready && ins_loc == i) begin
            list[i] <= new_entry;
         end else if (fin_hit[i] && fin_sel == i) begin
            list[i].conflict <= 1'b0;
         end
      end
   end

endmodule

//--- source/lowbit.sv
module lowbit #(
   parameter int in_width = 16
) (
   input logic [in_width-1:0] in,
   output logic [$clog2(in_width)-1:0] out
);

   localparam int out_w = $clog2(in_width);

   // scan from the top so the lowest set bit is kept last
   always_comb begin
      out = '0;
      for (int i = in_width - 1; i >= 0; i--) begin
         if (in[i]) begin
            out = out_w'(i);
         end
      end
   end

endmodule

//--- source/serializer_pkg.sv
`include "serializer_defs.svh"

package serializer_pkg;

   typedef logic [`SER_CORE_W-1:0] core_id_t;
   typedef logic [`SER_SLOT_W-1:0] slot_t;
   typedef logic [`SER_HINT_W-1:0] hint_t;
   // a core requests work by task type
   typedef logic [`SER_TTYPE_W-1:0] ttype_t;
   typedef logic [`SER_IDX_W-1:0] list_idx_t;
   typedef logic [`SER_CNT_W-1:0] count_t;

   typedef struct packed {
      ttype_t ttype;
      hint_t hint;
      logic [`SER_TS_W-1:0] ts;
   } task_t;

   typedef struct packed {
      ttype_t ttype;
      hint_t hint;
      slot_t slot;
      logic valid;
      logic conflict;
   } entry_t;

   // registered stage-1 decision
   typedef struct packed {
      logic valid;
      core_id_t core;
      list_idx_t idx;
   } grant_t;

   // read-only tasks must still serialize against writers
   function automatic hint_t ser_mask_hint(hint_t h);
      hint_t m;
      m = h;
      m[`SER_HINT_W-1] = 1'b0;
      return m;
   endfunction

endpackage

//--- source/serializer_defs.svh
`ifndef SERIALIZER_DEFS_SVH
`define SERIALIZER_DEFS_SVH

// core count and ready-list depth
`define SER_NUM_CORES 4
`define SER_LIST_DEPTH 16

// task field widths, top hint bit is the read-only flag
`define SER_HINT_W 16
`define SER_TTYPE_W 3
`define SER_TS_W 16

// task queue slot width
`define SER_SLOT_W 5

// request type that accepts a task of any type
`define SER_TTYPE_ANY 7

// derived sizes
`define SER_CORE_W $clog2(`SER_NUM_CORES)
`define SER_IDX_W $clog2(`SER_LIST_DEPTH)
`define SER_CNT_W ($clog2(`SER_LIST_DEPTH) + 1)
`define SER_NUM_TYPES (1 << `SER_TTYPE_W)

`endif
